// ==== list.f ====
+incdir+verification
hdl/cam_pkg.sv
hdl/pix_wr_if.sv
hdl/dvp_capture.sv
hdl/line_bank.sv
hdl/bank_reader.sv
hdl/cam_frame_buffer.sv
verification/tb_cam_frame_buffer.sv

// ==== run.sh ====
#!/usr/bin/env bash
# compile the camera frame buffer testbench with Verilator and run it
# the exit status is the simulator's, nonzero after a $fatal

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
  -f list.f \
  --top-module tb_cam_frame_buffer \
  -o sim_cam_frame_buffer \
  && ./obj_dir/sim_cam_frame_buffer \
  || { echo "simulation did not complete successfully"; exit 1; }

exit 0

// ==== verification/tb_camera_tasks.svh ====
`ifndef TB_CAMERA_TASKS_SVH
`define TB_CAMERA_TASKS_SVH

// ==================================================
// random source
// ==================================================
function automatic logic [31:0] next_random();
  lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
  return lcg_state;
endfunction

// one clock, read request driven on the falling edge
task automatic next_cycle();
  logic [31:0] r;
  @(negedge PCLK);
  case (rd_mode)
    0:       rd_en = 1'b0;
    1:       rd_en = 1'b1;
    default: begin
      r     = next_random();
      // requested on three cycles of four
      rd_en = (r[25:24] != 2'b00);
    end
  endcase
  // data_ready comes from registers, stable until the next rising edge
  if (RSTn_dly2 && rd_en && data_ready)
    req_accepted = req_accepted + 1;
endtask

// 32 bytes with href high, then the line gap
task automatic drive_line(input int line);
  for (int b = 0; b < LINE_BYTES; b++) begin
    next_cycle();
    href     = 1'b1;
    pic_data = frame_bytes[line * LINE_BYTES + b];
  end
  next_cycle();
  href     = 1'b0;
  pic_data = '0;
  repeat (LINE_GAP - 1) next_cycle();
endtask

task automatic drive_frame(input logic req, input int keep_lines);
  logic [31:0] r;
  int          total;
  total = (SKIP_LINES + V_LINES) * LINE_BYTES;
  frame_bytes.delete();
  for (int i = 0; i < total; i++) begin
    r = next_random();
    frame_bytes.push_back(r[23:16]);
  end
  // expected words are queued before the first byte goes out
  for (int i = 0; i < keep_lines * H_PIXELS; i++)
    exp_q.push_back(expected_word(i));
  next_cycle();
  frame_req = req;
  next_cycle();
  vsync = 1'b1;
  repeat (2) next_cycle();
  vsync = 1'b0;
  repeat (LINE_GAP) next_cycle();
  for (int l = 0; l < SKIP_LINES + V_LINES; l++)
    drive_line(l);
  // lets the capture FSM return to idle
  frame_req = 1'b0;
  repeat (2) next_cycle();
endtask

task automatic wait_drained();
  while (exp_q.size() != 0)
    next_cycle();
endtask

`endif

// ==== verification/tb_cam_frame_buffer.sv ====
`default_nettype none

module tb_cam_frame_buffer;
  import cam_pkg::*;

  localparam int LINE_BYTES   = 2 * H_PIXELS;
  localparam int LINE_GAP     = 8;
  localparam int FRAME_CYCLES = (SKIP_LINES + V_LINES) * (LINE_BYTES + LINE_GAP);
  // six frames of traffic with margin
  localparam int TIMEOUT_CYCLES = 6 * FRAME_CYCLES * 5 / 2;
  // lines the banks keep when nothing is read
  localparam int HELD_LINES = NUM_BANKS * BANK_DEPTH / H_PIXELS;

  typedef struct packed {
    logic [15:0] data;
    logic        first;
    logic        last;
  } exp_word_t;

  logic        PCLK;
  logic        RSTn_dly2;
  logic        vsync;
  logic        href;
  logic [7:0]  pic_data;
  logic        frame_req;
  logic        rd_en;
  logic        data_ready;
  logic        data_valid;
  logic [15:0] data_out;
  logic        data_first;
  logic        data_last;
  logic        overflow;

  byte_t       frame_bytes [$];
  exp_word_t   exp_q [$];
  logic [31:0] lcg_state;
  int          rd_mode;
  int          req_accepted = 0;
  int          words_seen   = 0;
  int          cycle_cnt    = 0;

  initial PCLK = 1'b0;
  always #4 PCLK = ~PCLK;

  cam_frame_buffer cam_frame_buffer_inst (
    .PCLK       (PCLK),
    .RSTn_dly2  (RSTn_dly2),
    .vsync      (vsync),
    .href       (href),
    .pic_data   (pic_data),
    .frame_req  (frame_req),
    .rd_en      (rd_en),
    .data_ready (data_ready),
    .data_valid (data_valid),
    .data_out   (data_out),
    .data_first (data_first),
    .data_last  (data_last),
    .overflow   (overflow)
  );

  // ==================================================
  // expected stream and checks
  // ==================================================
  // word idx of the stored part of the frame in frame_bytes
  function automatic exp_word_t expected_word(input int idx);
    int        line;
    int        pix;
    int        base;
    exp_word_t w;
    line    = idx / H_PIXELS;
    pix     = idx % H_PIXELS;
    // skipped lines never reach a bank
    base    = (SKIP_LINES + line) * LINE_BYTES + 2 * pix;
    w.data  = {frame_bytes[base + 1], frame_bytes[base]};
    w.first = (idx == 0);
    w.last  = (line == V_LINES - 1) && (pix == H_PIXELS - 1);
    return w;
  endfunction

  task automatic end_with_error(input string why);
    $display("%s", why);
    $display("Finished with errors");
    $fatal(1, "simulation stopped");
  endtask

  task automatic check_equal(input string name, input logic [31:0] got,
                             input logic [31:0] want);
    if (got !== want)
      end_with_error($sformatf("FAIL time=%0t signal=%s got=%0h expected=%0h",
                               $time, name, got, want));
  endtask

  `include "tb_camera_tasks.svh"

  // outputs are registered and stable at the falling edge
  always @(negedge PCLK) begin
    exp_word_t w;
    if (RSTn_dly2 && data_valid) begin
      words_seen = words_seen + 1;
      if (words_seen > req_accepted) begin
        end_with_error("data_valid seen without an accepted read request");
      end else if (exp_q.size() == 0) begin
        end_with_error("data_valid seen with no expected word left");
      end else begin
        w = exp_q.pop_front();
        check_equal("data_out", data_out, w.data);
        check_equal("data_first", data_first, w.first);
        check_equal("data_last", data_last, w.last);
      end
    end
  end

  always @(posedge PCLK) begin
    cycle_cnt = cycle_cnt + 1;
    if (cycle_cnt >= TIMEOUT_CYCLES)
      end_with_error($sformatf("timeout after %0d cycles, output stream incomplete",
                               cycle_cnt));
  end

  // ==================================================
  // test sequence
  // ==================================================
  initial begin
    RSTn_dly2 = 1'b0;
    vsync     = 1'b0;
    href      = 1'b0;
    pic_data  = '0;
    frame_req = 1'b0;
    rd_en     = 1'b0;
    lcg_state = 32'hd6ca;
    rd_mode   = 0;
    repeat (10) next_cycle();
    RSTn_dly2 = 1'b1;
    next_cycle();

    // quiet outputs after reset
    check_equal("data_valid", data_valid, 1'b0);
    check_equal("data_first", data_first, 1'b0);
    check_equal("data_last", data_last, 1'b0);
    check_equal("overflow", overflow, 1'b0);
    check_equal("data_ready", data_ready, 1'b0);

    // one frame with the reader always requesting
    rd_mode = 1;
    drive_frame(1'b1, V_LINES);
    wait_drained();
    check_equal("overflow", overflow, 1'b0);

    // no frame request and no reads, banks stay empty
    rd_mode = 0;
    drive_frame(1'b0, 0);
    check_equal("data_ready", data_ready, 1'b0);

    // two frames back to back with gaps in rd_en
    rd_mode = 2;
    drive_frame(1'b1, V_LINES);
    drive_frame(1'b1, V_LINES);
    wait_drained();
    check_equal("overflow", overflow, 1'b0);

    // reader stalled for a whole frame
    rd_mode = 0;
    drive_frame(1'b1, HELD_LINES);
    check_equal("overflow", overflow, 1'b1);
    rd_mode = 1;
    wait_drained();
    repeat (8) next_cycle();
    check_equal("data_ready", data_ready, 1'b0);
    rd_mode   = 0;
    RSTn_dly2 = 1'b0;
    repeat (2) next_cycle();
    check_equal("overflow", overflow, 1'b0);
    RSTn_dly2 = 1'b1;
    next_cycle();

    $display("Finished with no errors");
    $finish;
  end

endmodule

`default_nettype wire

// ==== hdl/cam_frame_buffer.sv ====
`default_nettype none

module cam_frame_buffer (
  input  logic        PCLK,
  input  logic        RSTn_dly2,
  input  logic        vsync,
  input  logic        href,
  input  logic [7:0]  pic_data,
  input  logic        frame_req,
  input  logic        rd_en,
  output logic        data_ready,
  output logic        data_valid,
  output logic [15:0] data_out,
  output logic        data_first,
  output logic        data_last,
  output logic        overflow
);
  import cam_pkg::*;

  // one write port per bank
  pix_wr_if   wr_if [NUM_BANKS] ();
  logic       bank_full  [NUM_BANKS];
  logic       bank_empty [NUM_BANKS];
  logic       bank_pop   [NUM_BANKS];
  bank_word_t bank_word  [NUM_BANKS];

  dvp_capture dvp_capture_inst (
    .PCLK      (PCLK),
    .RSTn_dly2 (RSTn_dly2),
    .vsync     (vsync),
    .href      (href),
    .pic_data  (pic_data),
    .frame_req (frame_req),
    .overflow  (overflow),
    .wr_port   (wr_if),
    .bank_full (bank_full)
  );

  // ==================================================
  // line banks
  // ==================================================
  for (genvar g = 0; g < NUM_BANKS; g++) begin : g_bank
    line_bank line_bank_inst (
      .PCLK      (PCLK),
      .RSTn_dly2 (RSTn_dly2),
      .wr_port   (wr_if[g]),
      .pop       (bank_pop[g]),
      .rd_word   (bank_word[g]),
      .empty     (bank_empty[g]),
      .full      (bank_full[g])
    );
  end

  bank_reader bank_reader_inst (
    .PCLK       (PCLK),
    .RSTn_dly2  (RSTn_dly2),
    .rd_en      (rd_en),
    .rd_word    (bank_word),
    .empty      (bank_empty),
    .pop        (bank_pop),
    .data_ready (data_ready),
    .data_valid (data_valid),
    .data_out   (data_out),
    .data_first (data_first),
    .data_last  (data_last)
  );

endmodule

`default_nettype wire

// ==== hdl/bank_reader.sv ====
`default_nettype none

module bank_reader (
  input  logic                PCLK,
  input  logic                RSTn_dly2,
  input  logic                rd_en,
  input  cam_pkg::bank_word_t rd_word [cam_pkg::NUM_BANKS],
  input  logic                empty [cam_pkg::NUM_BANKS],
  output logic                pop [cam_pkg::NUM_BANKS],
  output logic                data_ready,
  output logic                data_valid,
  output cam_pkg::pix_t       data_out,
  output logic                data_first,
  output logic                data_last
);
  import cam_pkg::*;

  bank_sel_t  cur_bank;
  bank_sel_t  next_bank;
  bank_sel_t  eff_bank;
  bank_word_t fly_word;
  logic       pop_q;
  logic       pop_any;
  logic       line_end;

  // ==================================================
  // bank pointer
  // ==================================================
  // word popped last cycle, now out of the bank register
  assign fly_word  = rd_word[cur_bank];
  assign line_end  = pop_q & fly_word[BW_EOL];
  assign next_bank = (cur_bank == bank_sel_t'(NUM_BANKS - 1)) ?
                     '0 : bank_sel_t'(cur_bank + 1'b1);
  // a line end moves the next pop over to the following bank
  assign eff_bank  = line_end ? next_bank : cur_bank;

  assign data_ready = ~empty[eff_bank];
  assign pop_any    = rd_en & data_ready;

  always_comb begin
    for (int i = 0; i < NUM_BANKS; i++) begin
      pop[i] = pop_any && (eff_bank == bank_sel_t'(i));
    end
  end

  always_ff @(posedge PCLK or negedge RSTn_dly2) begin
    if (!RSTn_dly2) begin
      cur_bank <= '0;
      pop_q    <= 1'b0;
    end else begin
      cur_bank <= eff_bank;
      pop_q    <= pop_any;
    end
  end

  // ==================================================
  // output stage
  // ==================================================
  always_ff @(posedge PCLK or negedge RSTn_dly2) begin
    if (!RSTn_dly2) begin
      data_valid <= 1'b0;
      data_first <= 1'b0;
      data_last  <= 1'b0;
    end else begin
      data_valid <= pop_q;
      data_first <= pop_q & fly_word[BW_SOF];
      data_last  <= pop_q & fly_word[BW_EOF];
    end
  end

  always_ff @(posedge PCLK) begin
    if (pop_q)
      data_out <= fly_word[$bits(pix_t)-1:0];
  end

  // two-cycle pop to output latency, never a word without a pop
  a_valid_needs_pop: assert property (@(posedge PCLK) disable iff (!RSTn_dly2)
    !pop_any |-> ##2 !data_valid);

endmodule

`default_nettype wire

// ==== hdl/line_bank.sv ====
`default_nettype none

module line_bank (
  input  logic                PCLK,
  input  logic                RSTn_dly2,
  pix_wr_if.bank              wr_port,
  input  logic                pop,
  output cam_pkg::bank_word_t rd_word,
  output logic                empty,
  output logic                full
);
  import cam_pkg::*;

  bank_word_t         mem [BANK_DEPTH];
  bank_word_t         wr_word;
  logic [BANK_AW-1:0] wr_ptr;
  logic [BANK_AW-1:0] rd_ptr;
  logic [BANK_AW:0]   count;
  logic               do_wr;
  logic               do_rd;

  // ==================================================
  // occupancy
  // ==================================================
  assign empty = (count == '0);
  assign full  = (count == (BANK_AW + 1)'(BANK_DEPTH));
  // writes into a full bank are lost
  assign do_wr = wr_port.wr & ~full;
  assign do_rd = pop & ~empty;

  always_comb begin
    wr_word[$bits(pix_t)-1:0] = wr_port.data;
    wr_word[BW_SOF]           = wr_port.sof;
    wr_word[BW_EOF]           = wr_port.eof;
    wr_word[BW_EOL]           = wr_port.eol;
  end

  always_ff @(posedge PCLK or negedge RSTn_dly2) begin
    if (!RSTn_dly2) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      // pointers wrap at the power-of-two depth
      if (do_wr)
        wr_ptr <= wr_ptr + 1'b1;
      if (do_rd)
        rd_ptr <= rd_ptr + 1'b1;
      case ({do_wr, do_rd})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  // ==================================================
  // storage and registered read
  // ==================================================
  always_ff @(posedge PCLK) begin
    if (do_wr)
      mem[wr_ptr] <= wr_word;
  end

  // word shows up the cycle after pop
  always_ff @(posedge PCLK) begin
    if (do_rd)
      rd_word <= mem[rd_ptr];
  end

  // reader must look at empty of this bank before popping
  a_no_pop_empty: assert property (@(posedge PCLK) disable iff (!RSTn_dly2)
    pop |-> !empty);

endmodule

`default_nettype wire

// ==== hdl/dvp_capture.sv ====
`default_nettype none

module dvp_capture (
  input  logic           PCLK,
  input  logic           RSTn_dly2,
  input  logic           vsync,
  input  logic           href,
  input  cam_pkg::byte_t pic_data,
  input  logic           frame_req,
  output logic           overflow,
  pix_wr_if.cap          wr_port [cam_pkg::NUM_BANKS],
  input  logic           bank_full [cam_pkg::NUM_BANKS]
);
  import cam_pkg::*;

  cap_state_t                  state;
  cap_state_t                  state_nxt;
  logic                        href_dly;
  logic                        href_fall;
  logic [LINE_CW-1:0]          line_cnt;
  logic [LINE_CW-1:0]          stored_line;
  logic [$clog2(H_PIXELS)-1:0] pix_cnt;
  logic                        hi_byte;
  logic                        store_byte;
  logic                        pix_done;
  logic                        line_last;
  bank_sel_t                   wr_sel;
  byte_t                       lo_byte;
  logic [NUM_BANKS-1:0]        wr_q;
  pix_t                        pix_q;
  logic                        sof_q;
  logic                        eof_q;
  logic                        eol_q;

  // ==================================================
  // frame state machine
  // ==================================================
  always_comb begin
    state_nxt = state;
    case (state)
      CAP_IDLE:  if (vsync && frame_req) state_nxt = CAP_LINES;
      CAP_LINES: if (line_cnt == LINE_CW'(SKIP_LINES + V_LINES)) state_nxt = CAP_DONE;
      CAP_DONE:  if (!frame_req) state_nxt = CAP_IDLE;
      default:   state_nxt = CAP_IDLE;
    endcase
  end

  always_ff @(posedge PCLK or negedge RSTn_dly2) begin
    if (!RSTn_dly2) begin
      state    <= CAP_IDLE;
      href_dly <= 1'b0;
    end else begin
      state    <= state_nxt;
      href_dly <= href;
    end
  end

  // ==================================================
  // line and pixel counters
  // ==================================================
  assign href_fall   = href_dly & ~href;
  assign store_byte  = (state == CAP_LINES) && href && (line_cnt >= LINE_CW'(SKIP_LINES));
  assign pix_done    = store_byte & hi_byte;
  assign stored_line = line_cnt - LINE_CW'(SKIP_LINES);
  assign line_last   = (pix_cnt == ($clog2(H_PIXELS))'(H_PIXELS - 1));
  // round-robin over banks, one line each
  assign wr_sel      = bank_sel_t'(stored_line % NUM_BANKS);

  always_ff @(posedge PCLK or negedge RSTn_dly2) begin
    if (!RSTn_dly2) begin
      line_cnt <= '0;
      pix_cnt  <= '0;
      hi_byte  <= 1'b0;
    end else begin
      if (state != CAP_LINES)
        line_cnt <= '0;
      else if (href_fall)
        line_cnt <= line_cnt + 1'b1;

      if (state != CAP_LINES || href_fall)
        pix_cnt <= '0;
      else if (pix_done)
        pix_cnt <= pix_cnt + 1'b1;

      // byte phase restarts at every line
      hi_byte <= store_byte ? ~hi_byte : 1'b0;
    end
  end

  // ==================================================
  // byte packer, first byte in the low half
  // ==================================================
  always_ff @(posedge PCLK) begin
    if (store_byte && !hi_byte)
      lo_byte <= pic_data;
    if (pix_done) begin
      pix_q <= {pic_data, lo_byte};
      sof_q <= (stored_line == '0) && (pix_cnt == '0);
      eol_q <= line_last;
      eof_q <= line_last && (stored_line == LINE_CW'(V_LINES - 1));
    end
  end

  always_ff @(posedge PCLK or negedge RSTn_dly2) begin
    if (!RSTn_dly2) begin
      wr_q     <= '0;
      overflow <= 1'b0;
    end else begin
      wr_q <= '0;
      if (pix_done && !bank_full[wr_sel])
        wr_q[wr_sel] <= 1'b1;
      // sticky until reset
      if (pix_done && bank_full[wr_sel])
        overflow <= 1'b1;
    end
  end

  for (genvar b = 0; b < NUM_BANKS; b++) begin : g_port
    assign wr_port[b].wr   = wr_q[b];
    assign wr_port[b].data = pix_q;
    assign wr_port[b].sof  = sof_q;
    assign wr_port[b].eof  = eof_q;
    assign wr_port[b].eol  = eol_q;
  end

  // the last write of a frame lands before the state leaves CAP_LINES
  a_wr_in_lines: assert property (@(posedge PCLK) disable iff (!RSTn_dly2)
    (|wr_q) |-> (state == CAP_LINES));

endmodule

`default_nettype wire

// ==== hdl/pix_wr_if.sv ====
`default_nettype none

interface pix_wr_if;
  import cam_pkg::*;

  // one-cycle write strobe
  logic wr;
  // pixel and flags, valid only with wr
  pix_t data;
  logic sof;
  logic eof;
  logic eol;

  modport cap (
    output wr,
    output data,
    output sof,
    output eof,
    output eol
  );

  // bank side cannot stall the camera
  modport bank (
    input wr,
    input data,
    input sof,
    input eof,
    input eol
  );
endinterface

`default_nettype wire

// ==== hdl/cam_pkg.sv ====
`default_nettype none

package cam_pkg;

  // ==================================================
  // frame geometry
  // ==================================================
  localparam int H_PIXELS   = 16;
  localparam int V_LINES    = 8;
  localparam int SKIP_LINES = 2;

  // line banks, two lines of pixels each
  localparam int NUM_BANKS  = 2;
  localparam int BANK_DEPTH = 32;
  localparam int BANK_AW    = 5;
  localparam int LINE_CW    = 4;

  // flag positions in a stored word
  localparam int BW_SOF = 16;
  localparam int BW_EOF = 17;
  localparam int BW_EOL = 18;

  typedef logic [7:0]  byte_t;
  typedef logic [15:0] pix_t;
  typedef logic [0:0]  bank_sel_t;
  typedef logic [18:0] bank_word_t;

  typedef enum logic [1:0] {
    CAP_IDLE  = 2'h0,
    CAP_LINES = 2'h1,
    CAP_DONE  = 2'h3
  } cap_state_t;

endpackage

`default_nettype wire
